/* common/lsu_pkg.sv */
package lsu_pkg;

    // ------------------------------------------------------------
    // Widths
    // ------------------------------------------------------------
    localparam int XLEN   = 32;
    localparam int STRB_W = XLEN / 8;
    localparam int OP_W   = 3;

    // Common word and option field types
    typedef logic [XLEN-1:0] word_t;
    typedef logic [OP_W-1:0] lsu_op_t;

    // ------------------------------------------------------------
    // Load option codes (funct3 of the load instructions)
    // ------------------------------------------------------------
    localparam lsu_op_t LD_LB  = 3'b000;
    localparam lsu_op_t LD_LH  = 3'b001;
    localparam lsu_op_t LD_LW  = 3'b010;
    localparam lsu_op_t LD_LBU = 3'b100;
    localparam lsu_op_t LD_LHU = 3'b101;

    // Store option codes
    localparam lsu_op_t ST_SB = 3'b000;
    localparam lsu_op_t ST_SH = 3'b001;
    localparam lsu_op_t ST_SW = 3'b010;

    // ------------------------------------------------------------
    // AXI size codes, bytes per beat as a power of two
    // ------------------------------------------------------------
    localparam logic [2:0] SIZE_BYTE = 3'b000;
    localparam logic [2:0] SIZE_HALF = 3'b001;
    localparam logic [2:0] SIZE_WORD = 3'b010;

    // ------------------------------------------------------------
    // Request payloads
    // ------------------------------------------------------------

    // AR and AW beat
    typedef struct packed {
        word_t      addr;
        logic [2:0] size;
    } addr_req_t;

    // W beat, data already lane aligned
    typedef struct packed {
        word_t             data;
        logic [STRB_W-1:0] strb;
    } wdata_req_t;

endpackage

/* rtl/axi_req_channel.sv */
`timescale 1ns/10ps

module axi_req_channel #(
    parameter type payload_t = logic
) (
    input  logic     M_AXI_ACLK,
    input  logic     M_AXI_ARESETN,
    input  logic     i_start,
    input  payload_t i_payload,
    input  logic     i_ready,
    output logic     o_valid,
    output payload_t o_payload
);

    logic     valid_q;
    payload_t payload_q;

    // Valid rises on a start and falls on the handshake
    always_ff @(posedge M_AXI_ACLK)
    begin
        if (!M_AXI_ARESETN)
        begin
            valid_q <= 1'b0;
        end
        else if (i_start)
        begin
            valid_q <= 1'b1;
        end
        else if (valid_q && i_ready)
        begin
            valid_q <= 1'b0;
        end
    end

    // Payload only loads on start so it stays stable while waiting for ready
    always_ff @(posedge M_AXI_ACLK)
    begin
        if (i_start)
        begin
            payload_q <= i_payload;
        end
    end

    assign o_valid   = valid_q;
    assign o_payload = payload_q;

endmodule

/* load/lsu_load_path.sv */
`timescale 1ns/10ps

module lsu_load_path (
    input  logic             M_AXI_ACLK,
    input  logic             M_AXI_ARESETN,
    input  logic             i_start,
    input  lsu_pkg::word_t   i_addr,
    input  lsu_pkg::lsu_op_t i_load_opt,

    // AXI read side
    output lsu_pkg::word_t   o_araddr,
    output logic [2:0]       o_arsize,
    output logic             o_arvalid,
    output logic             o_rready,
    input  logic             i_arready,
    input  lsu_pkg::word_t   i_rdata,
    input  logic             i_rvalid,

    // Result toward the sequencer
    output logic             o_done,
    output lsu_pkg::word_t   o_data
);

    lsu_pkg::addr_req_t ar_req;
    lsu_pkg::addr_req_t ar_out;
    lsu_pkg::lsu_op_t   opt_q;
    logic [1:0]         offset_q;
    logic               rready_q;
    logic               r_fire;
    logic               done_q;
    lsu_pkg::word_t     rdata_q;
    lsu_pkg::word_t     shifted;

    // ------------------------------------------------------------
    // Read address
    // ------------------------------------------------------------
    always_comb
    begin
        ar_req.addr = i_addr;
        case (i_load_opt)
            lsu_pkg::LD_LB, lsu_pkg::LD_LBU: ar_req.size = lsu_pkg::SIZE_BYTE;
            lsu_pkg::LD_LH, lsu_pkg::LD_LHU: ar_req.size = lsu_pkg::SIZE_HALF;
            default:                         ar_req.size = lsu_pkg::SIZE_WORD;
        endcase
    end

    axi_req_channel #(
        .payload_t (lsu_pkg::addr_req_t)
    ) u_ar (
        .M_AXI_ACLK    (M_AXI_ACLK),
        .M_AXI_ARESETN (M_AXI_ARESETN),
        .i_start       (i_start),
        .i_payload     (ar_req),
        .i_ready       (i_arready),
        .o_valid       (o_arvalid),
        .o_payload     (ar_out)
    );

    assign o_araddr = ar_out.addr;
    assign o_arsize = ar_out.size;

    // Option and byte offset are needed again when the data returns
    always_ff @(posedge M_AXI_ACLK)
    begin
        if (i_start)
        begin
            opt_q    <= i_load_opt;
            offset_q <= i_addr[1:0];
        end
    end

    // ------------------------------------------------------------
    // Read data
    // ------------------------------------------------------------
    assign r_fire = i_rvalid && rready_q;

    always_ff @(posedge M_AXI_ACLK)
    begin
        if (!M_AXI_ARESETN)
        begin
            rready_q <= 1'b0;
            done_q   <= 1'b0;
        end
        else
        begin
            if (i_start)
                rready_q <= 1'b1;
            else if (r_fire)
                rready_q <= 1'b0;
            done_q <= r_fire;
        end
    end

    always_ff @(posedge M_AXI_ACLK)
    begin
        if (r_fire)
        begin
            rdata_q <= i_rdata;
        end
    end

    // Move the addressed byte lane down to bit 0, then extend
    assign shifted = rdata_q >> {offset_q, 3'b000};

    always_comb
    begin
        case (opt_q)
            lsu_pkg::LD_LB:  o_data = {{24{shifted[7]}}, shifted[7:0]};
            lsu_pkg::LD_LH:  o_data = {{16{shifted[15]}}, shifted[15:0]};
            lsu_pkg::LD_LW:  o_data = shifted;
            lsu_pkg::LD_LBU: o_data = {24'b0, shifted[7:0]};
            lsu_pkg::LD_LHU: o_data = {16'b0, shifted[15:0]};
            default:         o_data = '0;
        endcase
    end

    assign o_rready = rready_q;
    assign o_done   = done_q;

endmodule

/* store/lsu_store_path.sv */
`timescale 1ns/10ps

module lsu_store_path (
    input  logic                       M_AXI_ACLK,
    input  logic                       M_AXI_ARESETN,
    input  logic                       i_start,
    input  lsu_pkg::word_t             i_addr,
    input  lsu_pkg::word_t             i_src2,
    input  lsu_pkg::lsu_op_t           i_store_opt,

    // AXI write side
    output lsu_pkg::word_t             o_awaddr,
    output logic [2:0]                 o_awsize,
    output logic                       o_awvalid,
    output lsu_pkg::word_t             o_wdata,
    output logic [lsu_pkg::STRB_W-1:0] o_wstrb,
    output logic                       o_wlast,
    output logic                       o_wvalid,
    output logic                       o_bready,
    input  logic                       i_awready,
    input  logic                       i_wready,
    input  logic                       i_bvalid,

    output logic                       o_done
);

    lsu_pkg::addr_req_t          aw_req;
    lsu_pkg::addr_req_t          aw_out;
    lsu_pkg::wdata_req_t         w_req;
    lsu_pkg::wdata_req_t         w_out;
    logic [lsu_pkg::STRB_W-1:0]  base_strb;
    logic                        aw_fire;
    logic                        w_fire;
    logic                        b_fire;
    logic                        aw_acc_q;
    logic                        w_acc_q;
    logic                        bready_q;
    logic                        done_q;

    // ------------------------------------------------------------
    // Request payloads, built from the operands at start
    // ------------------------------------------------------------
    always_comb
    begin
        case (i_store_opt)
            lsu_pkg::ST_SB: base_strb = 4'b0001;
            lsu_pkg::ST_SH: base_strb = 4'b0011;
            lsu_pkg::ST_SW: base_strb = 4'b1111;
            default:        base_strb = 4'b0000;
        endcase

        aw_req.addr = i_addr;
        case (i_store_opt)
            lsu_pkg::ST_SB: aw_req.size = lsu_pkg::SIZE_BYTE;
            lsu_pkg::ST_SH: aw_req.size = lsu_pkg::SIZE_HALF;
            default:        aw_req.size = lsu_pkg::SIZE_WORD;
        endcase

        // Source moves up into the lanes picked by the low address bits
        w_req.data = i_src2 << {i_addr[1:0], 3'b000};
        w_req.strb = base_strb << i_addr[1:0];
    end

    axi_req_channel #(
        .payload_t (lsu_pkg::addr_req_t)
    ) u_aw (
        .M_AXI_ACLK    (M_AXI_ACLK),
        .M_AXI_ARESETN (M_AXI_ARESETN),
        .i_start       (i_start),
        .i_payload     (aw_req),
        .i_ready       (i_awready),
        .o_valid       (o_awvalid),
        .o_payload     (aw_out)
    );

    axi_req_channel #(
        .payload_t (lsu_pkg::wdata_req_t)
    ) u_w (
        .M_AXI_ACLK    (M_AXI_ACLK),
        .M_AXI_ARESETN (M_AXI_ARESETN),
        .i_start       (i_start),
        .i_payload     (w_req),
        .i_ready       (i_wready),
        .o_valid       (o_wvalid),
        .o_payload     (w_out)
    );

    // ------------------------------------------------------------
    // Acceptance tracking and write response
    // ------------------------------------------------------------
    assign aw_fire = o_awvalid && i_awready;
    assign w_fire  = o_wvalid && i_wready;
    assign b_fire  = bready_q && i_bvalid;

    always_ff @(posedge M_AXI_ACLK)
    begin
        if (!M_AXI_ARESETN || i_start || b_fire)
        begin
            aw_acc_q <= 1'b0;
            w_acc_q  <= 1'b0;
        end
        else
        begin
            if (aw_fire)
                aw_acc_q <= 1'b1;
            if (w_fire)
                w_acc_q <= 1'b1;
        end
    end

    // BREADY once both AW and W are through, in either order
    always_ff @(posedge M_AXI_ACLK)
    begin
        if (!M_AXI_ARESETN)
        begin
            bready_q <= 1'b0;
            done_q   <= 1'b0;
        end
        else
        begin
            if (b_fire)
                bready_q <= 1'b0;
            else if ((aw_acc_q || aw_fire) && (w_acc_q || w_fire))
                bready_q <= 1'b1;
            done_q <= b_fire;
        end
    end

    assign o_awaddr = aw_out.addr;
    assign o_awsize = aw_out.size;
    assign o_wdata  = w_out.data;
    assign o_wstrb  = w_out.strb;
    assign o_wlast  = o_wvalid;     // single beat
    assign o_bready = bready_q;
    assign o_done   = done_q;

endmodule

/* rtl/lsu_sequencer.sv */
`timescale 1ns/10ps

module lsu_sequencer (
    input  logic          M_AXI_ACLK,
    input  logic          M_AXI_ARESETN,
    input  logic          i_pre_valid,
    input  logic          i_load,
    input  logic          i_store,
    input  logic          i_load_done,
    input  logic          i_store_done,
    input  lsu_pkg::word_t i_load_data,
    output logic          o_load_start,
    output logic          o_store_start,
    output logic          o_post_valid,
    output lsu_pkg::word_t o_lsu_res
);

    logic           nonmem_start;
    logic           post_valid_q;
    lsu_pkg::word_t lsu_res_q;

    // Steer the start pulse, load has priority
    assign o_load_start  = i_pre_valid && i_load;
    assign o_store_start = i_pre_valid && i_store && !i_load;
    assign nonmem_start  = i_pre_valid && !i_load && !i_store;

    // Completion toward write-back, one cycle after any done
    always_ff @(posedge M_AXI_ACLK)
    begin
        if (!M_AXI_ARESETN)
        begin
            post_valid_q <= 1'b0;
        end
        else
        begin
            post_valid_q <= nonmem_start || i_load_done || i_store_done;
        end
    end

    // Result holds until the next completed load
    always_ff @(posedge M_AXI_ACLK)
    begin
        if (!M_AXI_ARESETN)
        begin
            lsu_res_q <= '0;
        end
        else if (i_load_done)
        begin
            lsu_res_q <= i_load_data;
        end
    end

    assign o_post_valid = post_valid_q;
    assign o_lsu_res    = lsu_res_q;

endmodule

/* rtl/lsu_top.sv */
`timescale 1ns/10ps

module lsu_top (
    input  logic                       M_AXI_ACLK,
    input  logic                       M_AXI_ARESETN,

    // Pipeline side
    input  logic                       i_pre_valid,
    input  logic                       i_load,
    input  logic                       i_store,
    input  lsu_pkg::word_t             i_addr,
    input  lsu_pkg::word_t             i_src2,
    input  lsu_pkg::lsu_op_t           i_load_opt,
    input  lsu_pkg::lsu_op_t           i_store_opt,
    output logic                       o_post_valid,
    output lsu_pkg::word_t             o_lsu_res,

    // Write address channel
    output lsu_pkg::word_t             o_M_AXI_AWADDR,
    output logic [2:0]                 o_M_AXI_AWSIZE,
    output logic                       o_M_AXI_AWVALID,
    input  logic                       i_M_AXI_AWREADY,

    // Write data channel
    output lsu_pkg::word_t             o_M_AXI_WDATA,
    output logic [lsu_pkg::STRB_W-1:0] o_M_AXI_WSTRB,
    output logic                       o_M_AXI_WLAST,
    output logic                       o_M_AXI_WVALID,
    input  logic                       i_M_AXI_WREADY,

    // Write response channel
    input  logic                       i_M_AXI_BVALID,
    output logic                       o_M_AXI_BREADY,

    // Read address channel
    output lsu_pkg::word_t             o_M_AXI_ARADDR,
    output logic [2:0]                 o_M_AXI_ARSIZE,
    output logic                       o_M_AXI_ARVALID,
    input  logic                       i_M_AXI_ARREADY,

    // Read data channel
    input  lsu_pkg::word_t             i_M_AXI_RDATA,
    input  logic                       i_M_AXI_RVALID,
    output logic                       o_M_AXI_RREADY
);

    logic           load_start;
    logic           store_start;
    logic           load_done;
    logic           store_done;
    lsu_pkg::word_t load_data;

    lsu_sequencer u_seq (
        .M_AXI_ACLK    (M_AXI_ACLK),
        .M_AXI_ARESETN (M_AXI_ARESETN),
        .i_pre_valid   (i_pre_valid),
        .i_load        (i_load),
        .i_store       (i_store),
        .i_load_done   (load_done),
        .i_store_done  (store_done),
        .i_load_data   (load_data),
        .o_load_start  (load_start),
        .o_store_start (store_start),
        .o_post_valid  (o_post_valid),
        .o_lsu_res     (o_lsu_res)
    );

    lsu_load_path u_load (
        .M_AXI_ACLK    (M_AXI_ACLK),
        .M_AXI_ARESETN (M_AXI_ARESETN),
        .i_start       (load_start),
        .i_addr        (i_addr),
        .i_load_opt    (i_load_opt),
        .o_araddr      (o_M_AXI_ARADDR),
        .o_arsize      (o_M_AXI_ARSIZE),
        .o_arvalid     (o_M_AXI_ARVALID),
        .o_rready      (o_M_AXI_RREADY),
        .i_arready     (i_M_AXI_ARREADY),
        .i_rdata       (i_M_AXI_RDATA),
        .i_rvalid      (i_M_AXI_RVALID),
        .o_done        (load_done),
        .o_data        (load_data)
    );

    lsu_store_path u_store (
        .M_AXI_ACLK    (M_AXI_ACLK),
        .M_AXI_ARESETN (M_AXI_ARESETN),
        .i_start       (store_start),
        .i_addr        (i_addr),
        .i_src2        (i_src2),
        .i_store_opt   (i_store_opt),
        .o_awaddr      (o_M_AXI_AWADDR),
        .o_awsize      (o_M_AXI_AWSIZE),
        .o_awvalid     (o_M_AXI_AWVALID),
        .o_wdata       (o_M_AXI_WDATA),
        .o_wstrb       (o_M_AXI_WSTRB),
        .o_wlast       (o_M_AXI_WLAST),
        .o_wvalid      (o_M_AXI_WVALID),
        .o_bready      (o_M_AXI_BREADY),
        .i_awready     (i_M_AXI_AWREADY),
        .i_wready      (i_M_AXI_WREADY),
        .i_bvalid      (i_M_AXI_BVALID),
        .o_done        (store_done)
    );

endmodule

/* testbench/tb_clock_gen.sv */
`timescale 1ns/10ps

module tb_clock_gen (
    output logic o_clk,
    output logic o_rst_n
);

    localparam int RESET_CYCLES = 8;

    // 20 ns period
    initial
    begin
        o_clk = 1'b0;
        forever #10 o_clk = ~o_clk;
    end

    // Release reset on a falling edge so the first active edge sees it cleanly
    initial
    begin
        o_rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge o_clk);
        @(negedge o_clk);
        o_rst_n = 1'b1;
    end

endmodule

/* testbench/lsu_props.sv */
`timescale 1ns/10ps

module lsu_props (
    input logic        M_AXI_ACLK,
    input logic        M_AXI_ARESETN,
    input logic        o_M_AXI_ARVALID,
    input logic        i_M_AXI_ARREADY,
    input logic [31:0] o_M_AXI_ARADDR,
    input logic [2:0]  o_M_AXI_ARSIZE,
    input logic        o_M_AXI_AWVALID,
    input logic        i_M_AXI_AWREADY,
    input logic [31:0] o_M_AXI_AWADDR,
    input logic [2:0]  o_M_AXI_AWSIZE,
    input logic        o_M_AXI_WVALID,
    input logic        i_M_AXI_WREADY,
    input logic [31:0] o_M_AXI_WDATA,
    input logic [3:0]  o_M_AXI_WSTRB,
    input logic        o_M_AXI_RREADY,
    input logic        o_M_AXI_BREADY,
    input logic        o_post_valid
);

    // ------------------------------------------------------------
    // Requests hold until accepted
    // ------------------------------------------------------------
    ar_hold: assert property (@(posedge M_AXI_ACLK) disable iff (!M_AXI_ARESETN)
        (o_M_AXI_ARVALID && !i_M_AXI_ARREADY) |=>
        (o_M_AXI_ARVALID && $stable(o_M_AXI_ARADDR) && $stable(o_M_AXI_ARSIZE)))
        else $error("ARVALID or AR payload changed before ARREADY");

    aw_hold: assert property (@(posedge M_AXI_ACLK) disable iff (!M_AXI_ARESETN)
        (o_M_AXI_AWVALID && !i_M_AXI_AWREADY) |=>
        (o_M_AXI_AWVALID && $stable(o_M_AXI_AWADDR) && $stable(o_M_AXI_AWSIZE)))
        else $error("AWVALID or AW payload changed before AWREADY");

    w_hold: assert property (@(posedge M_AXI_ACLK) disable iff (!M_AXI_ARESETN)
        (o_M_AXI_WVALID && !i_M_AXI_WREADY) |=>
        (o_M_AXI_WVALID && $stable(o_M_AXI_WDATA) && $stable(o_M_AXI_WSTRB)))
        else $error("WVALID or W payload changed before WREADY");

    // Write-back pulse is a single cycle
    post_pulse: assert property (@(posedge M_AXI_ACLK) disable iff (!M_AXI_ARESETN)
        o_post_valid |=> !o_post_valid)
        else $error("o_post_valid high two cycles in a row");

    // Registers are cleared by one reset edge
    reset_quiet: assert property (@(posedge M_AXI_ACLK)
        !M_AXI_ARESETN |=> !(o_M_AXI_ARVALID || o_M_AXI_AWVALID || o_M_AXI_WVALID
        || o_M_AXI_RREADY || o_M_AXI_BREADY || o_post_valid))
        else $error("Valid or ready high after a reset cycle");

endmodule

bind lsu_top lsu_props u_props (.*);

/* testbench/tb_lsu.sv */
`timescale 1ns/10ps

module tb_lsu;

    localparam int RAND_OPS     = 200;
    localparam int DIRECTED_OPS = 48;
    localparam int MAX_CYCLES   = (RAND_OPS + DIRECTED_OPS) * 12 + 100;

    logic clk, rst_n;
    logic pre_valid, load, store, post_valid;
    logic [31:0] addr, src2, lsu_res, awaddr, wdata, araddr, rdata;
    logic [2:0] load_opt, store_opt, awsize, arsize;
    logic [3:0] wstrb;
    logic awvalid, awready, wlast, wvalid, wready, bvalid, bready;
    logic arvalid, arready, rvalid, rready;

    integer seed = 3964;
    int errors = 0;
    int checks = 0;
    int cycles = 0;
    int op_count = 0;
    int post_count = 0;
    logic [31:0] mem [64];
    logic [31:0] shadow [64];
    lsu_pkg::lsu_op_t ld_sel [8];
    lsu_pkg::lsu_op_t st_sel [4];

    // Expected state for the compare process
    logic [31:0] exp_res = '0, last_res = '0, since_start = '0;
    logic [2:0] exp_size = '0;
    logic exp_nonmem = 1'b0;
    string exp_name = "none";

    // Slave model state
    logic rd_pend, aw_got, w_got, b_pend;
    logic [1:0] rd_delay, b_delay;
    logic [5:0] rd_idx, aw_idx;
    logic [31:0] w_data_q;
    logic [3:0] w_strb_q;

    tb_clock_gen u_clk (.o_clk(clk), .o_rst_n(rst_n));

    lsu_top dut (
        .M_AXI_ACLK(clk), .M_AXI_ARESETN(rst_n),
        .i_pre_valid(pre_valid), .i_load(load), .i_store(store),
        .i_addr(addr), .i_src2(src2), .i_load_opt(load_opt), .i_store_opt(store_opt),
        .o_post_valid(post_valid), .o_lsu_res(lsu_res),
        .o_M_AXI_AWADDR(awaddr), .o_M_AXI_AWSIZE(awsize), .o_M_AXI_AWVALID(awvalid),
        .i_M_AXI_AWREADY(awready), .o_M_AXI_WDATA(wdata), .o_M_AXI_WSTRB(wstrb),
        .o_M_AXI_WLAST(wlast), .o_M_AXI_WVALID(wvalid), .i_M_AXI_WREADY(wready),
        .i_M_AXI_BVALID(bvalid), .o_M_AXI_BREADY(bready),
        .o_M_AXI_ARADDR(araddr), .o_M_AXI_ARSIZE(arsize), .o_M_AXI_ARVALID(arvalid),
        .i_M_AXI_ARREADY(arready), .i_M_AXI_RDATA(rdata), .i_M_AXI_RVALID(rvalid),
        .o_M_AXI_RREADY(rready)
    );

    // ------------------------------------------------------------
    // Reference model
    // ------------------------------------------------------------
    function automatic logic [31:0] ref_load(logic [31:0] word, logic [2:0] opt,
                                             logic [1:0] off);
        logic [31:0] s;
        s = word >> (8 * off);
        case (opt)
            3'd0:    return {{24{s[7]}}, s[7:0]};
            3'd1:    return {{16{s[15]}}, s[15:0]};
            3'd2:    return s;
            3'd4:    return {24'd0, s[7:0]};
            3'd5:    return {16'd0, s[15:0]};
            default: return 32'd0;
        endcase
    endfunction

    function automatic logic [31:0] ref_store(logic [31:0] old, logic [31:0] src,
                                              logic [2:0] opt, logic [1:0] off);
        logic [3:0] strb;
        logic [31:0] data;
        logic [31:0] res;
        case (opt)
            3'd0:    strb = 4'b0001;
            3'd1:    strb = 4'b0011;
            3'd2:    strb = 4'b1111;
            default: strb = 4'b0000;
        endcase
        strb = strb << off;
        data = src << (8 * off);
        res = old;
        for (int b = 0; b < 4; b++)
            if (strb[b])
                res[8*b +: 8] = data[8*b +: 8];
        return res;
    endfunction

    // Byte, half and word options share the low two bits for loads and stores
    function automatic logic [2:0] size_for(logic [2:0] opt);
        case (opt[1:0])
            2'd0:    return 3'd0;
            2'd1:    return 3'd1;
            default: return 3'd2;
        endcase
    endfunction

    task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
        checks++;
        if (exp !== act)
        begin
            $display("FAILED %s expected %h actual %h", name, exp, act);
            errors++;
        end
    endtask

    // ------------------------------------------------------------
    // AXI slave model
    // ------------------------------------------------------------
    always @(posedge clk)
    begin
        logic [31:0] r;
        if (!rst_n)
        begin
            rd_pend = 1'b0;
            aw_got  = 1'b0;
            w_got   = 1'b0;
            b_pend  = 1'b0;
        end
        else
        begin
            r = $random(seed);
            if (arvalid && arready)
            begin
                check("arsize", {29'd0, exp_size}, {29'd0, arsize});
                rd_idx   = araddr[7:2];
                rd_delay = r[1:0];
                rd_pend  = 1'b1;
            end
            if (rvalid && rready)
                rd_pend = 1'b0;
            if (awvalid && awready)
            begin
                check("awsize", {29'd0, exp_size}, {29'd0, awsize});
                aw_idx = awaddr[7:2];
                aw_got = 1'b1;
            end
            if (wvalid && wready)
            begin
                check("wlast", 32'd1, {31'd0, wlast});
                w_data_q = wdata;
                w_strb_q = wstrb;
                w_got    = 1'b1;
            end
            if (aw_got && w_got)
            begin
                for (int b = 0; b < 4; b++)
                    if (w_strb_q[b])
                        mem[aw_idx][8*b +: 8] = w_data_q[8*b +: 8];
                aw_got  = 1'b0;
                w_got   = 1'b0;
                b_pend  = 1'b1;
                b_delay = r[3:2];
            end
            if (bvalid && bready)
                b_pend = 1'b0;
        end
    end

    always @(negedge clk)
    begin
        logic [31:0] r;
        if (!rst_n)
        begin
            {arready, awready, wready, rvalid, bvalid} = 5'd0;
        end
        else
        begin
            r = $random(seed);
            arready = r[0];
            awready = r[1];
            wready  = r[2];
            if (!rd_pend)
                rvalid = 1'b0;
            else if (!rvalid)
            begin
                if (rd_delay == 2'd0)
                begin
                    rvalid = 1'b1;
                    rdata  = mem[rd_idx];
                end
                else
                    rd_delay = rd_delay - 2'd1;
            end
            if (!b_pend)
                bvalid = 1'b0;
            else if (!bvalid)
            begin
                if (b_delay == 2'd0)
                    bvalid = 1'b1;
                else
                    b_delay = b_delay - 2'd1;
            end
        end
    end

    // ------------------------------------------------------------
    // Compare process and timeout
    // ------------------------------------------------------------
    always @(posedge clk)
    begin
        if (rst_n)
        begin
            if (post_valid)
            begin
                post_count++;
                if (exp_nonmem)
                    check("nonmem_latency", 32'd1, since_start);
                check(exp_name, exp_res, lsu_res);
            end
            if (pre_valid)
                since_start = 32'd1;
            else
                since_start = since_start + 32'd1;
        end
    end

    always @(posedge clk)
    begin
        cycles++;
        if (cycles > MAX_CYCLES)
        begin
            $display("Timeout: no completion within %0d cycles", MAX_CYCLES);
            $display("TEST FAILED");
            $finish;
        end
    end

    // kind 0 is a load, 1 a store, 2 a non-memory instruction
    task automatic issue(input int kind, input logic [31:0] a, input logic [31:0] src,
                         input logic [2:0] opt, input string name);
        int target;
        exp_name   = name;
        exp_size   = size_for(opt);
        exp_nonmem = (kind == 2);
        if (kind == 0)
            last_res = ref_load(shadow[a[7:2]], opt, a[1:0]);
        if (kind == 1)
            shadow[a[7:2]] = ref_store(shadow[a[7:2]], src, opt, a[1:0]);
        exp_res = last_res;
        target  = post_count + 1;
        op_count++;
        @(negedge clk);
        pre_valid = 1'b1;
        load      = (kind == 0);
        store     = (kind == 1);
        addr      = a;
        src2      = src;
        load_opt  = opt;
        store_opt = opt;
        @(negedge clk);
        {pre_valid, load, store} = 3'd0;
        while (post_count < target)
            @(negedge clk);
    endtask

    initial
    begin
        logic [31:0] r;
        {pre_valid, load, store, load_opt, store_opt} = '0;
        {addr, src2} = '0;
        {arready, awready, wready, rvalid, bvalid} = 5'd0;
        rdata = '0;
        ld_sel = '{lsu_pkg::LD_LB, lsu_pkg::LD_LH, lsu_pkg::LD_LW, lsu_pkg::LD_LBU,
                   lsu_pkg::LD_LHU, lsu_pkg::LD_LB, lsu_pkg::LD_LW, lsu_pkg::LD_LHU};
        st_sel = '{lsu_pkg::ST_SB, lsu_pkg::ST_SH, lsu_pkg::ST_SW, lsu_pkg::ST_SW};
        for (int i = 0; i < 64; i++)
        begin
            mem[i]    = (32'h9e3779b9 * (i + 1)) ^ (i << 20);
            shadow[i] = mem[i];
        end
        wait (rst_n);

        for (int o = 0; o < 5; o++)
            for (int off = 0; off < 4; off++)
            begin
                r = $random(seed);
                issue(0, {24'd0, r[5:0], off[1:0]}, 32'd0, ld_sel[o], "load_offset");
            end
        for (int o = 0; o < 3; o++)
            for (int off = 0; off < 4; off++)
            begin
                r = $random(seed);
                issue(1, {24'd0, r[5:0], off[1:0]}, $random(seed), st_sel[o], "store");
                issue(0, {24'd0, r[5:0], 2'd0}, 32'd0, lsu_pkg::LD_LW, "store_readback");
            end
        repeat (4)
            issue(2, 32'd0, 32'd0, 3'd0, "nonmem");

        for (int n = 0; n < RAND_OPS; n++)
        begin
            r = $random(seed);
            case (r[11:10])
                2'd1:    issue(1, {24'd0, r[7:0]}, $random(seed), st_sel[r[13:12]], "rand_store");
                2'd2:    issue(2, 32'd0, 32'd0, 3'd0, "rand_nonmem");
                default: issue(0, {24'd0, r[7:0]}, 32'd0, ld_sel[r[14:12]], "rand_load");
            endcase
        end

        repeat (4) @(negedge clk);
        check("post_valid_count", op_count, post_count);
        $display("Checks %0d errors %0d", checks, errors);
        if (errors == 0)
            $display("TEST PASSED");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule

/* all.f */
common/lsu_pkg.sv
rtl/axi_req_channel.sv
load/lsu_load_path.sv
store/lsu_store_path.sv
rtl/lsu_sequencer.sv
rtl/lsu_top.sv
testbench/tb_clock_gen.sv
testbench/lsu_props.sv
testbench/tb_lsu.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := tb_lsu
FILELIST  := all.f
BUILD_DIR := obj_dir
LOG       := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and check the log for the pass message"
	@echo "  clean  remove build output and log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "^TEST PASSED$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
